// ==== common/line_pkg.sv ====
package line_pkg;

	//////////////////////////////////////////////////////////////////////
	// Line geometry and keystream constants
	//////////////////////////////////////////////////////////////////////

	localparam int LINE_WORDS = 4;

	// Golden-ratio multiplier spreads neighbouring addresses apart
	localparam logic [31:0] KS_STEP = 32'h9E37_79B9;

	// One 128-bit line, seen as words by the guards and as raw bits by the RAM
	typedef union packed {
		logic [LINE_WORDS-1:0][31:0] words;
		logic [32*LINE_WORDS-1:0]    raw;
	} line_u;

	// Request from a refill port, plaintext
	typedef struct packed {
		logic        write;
		logic [15:0] addr;
		line_u       data;
	} port_req_t;

	// Response to a refill port
	typedef struct packed {
		line_u data;
		logic  ack;
	} port_rsp_t;

	// Request toward the RAM, data already scrambled
	typedef struct packed {
		logic        write;
		logic [15:0] addr;
		line_u       data;
	} mem_req_t;

	//////////////////////////////////////////////////////////////////////
	// Keystream generator
	//////////////////////////////////////////////////////////////////////

	// Word k = key ^ (addr * KS_STEP) ^ (k * 0x01010101)
	function automatic line_u keystream(input logic [31:0] key, input logic [15:0] addr);
		line_u       ks;
		logic [31:0] addr_mix;
		addr_mix = 32'(addr) * KS_STEP;
		for (int k = 0; k < LINE_WORDS; k++)
		begin
			ks.words[k] = key ^ addr_mix ^ (32'(k) * 32'h0101_0101);
		end
		return ks;
	endfunction

endpackage

// ==== hdl/line_ram.sv ====
`timescale 1ns/1ps

module line_ram
	import line_pkg::*;
#(
	parameter int ADDR_BITS = 8
)
(
	input  logic     sys_clock,
	input  logic     reset,
	input  logic     en_i,
	input  mem_req_t req_i,
	output line_u    rdata_o
);

	localparam int DEPTH = 1 << ADDR_BITS;

	// Storage holds scrambled lines only
	logic [32*LINE_WORDS-1:0] mem_q [DEPTH];
	line_u                    rdata_q;
	logic [ADDR_BITS-1:0]     addr;

	// Upper address bits are outside the RAM
	assign addr = req_i.addr[ADDR_BITS-1:0];

	//////////////////////////////////////////////////////////////////////
	// Single port, write-first not needed since one access per enable
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clock)
	begin
		if (en_i)
		begin
			if (req_i.write)
			begin
				mem_q[addr] <= req_i.data.raw;
			end
			else
			begin
				// Read data shows up the cycle after the enable
				rdata_q.raw <= mem_q[addr];
			end
		end
	end

	// Register keeps the last read line until the next read
	assign rdata_o = rdata_q;

	// An X address on an enabled access would corrupt an unknown line
	a_addr_known : assert property (
		@(posedge sys_clock) disable iff (reset)
		en_i |-> !$isunknown(addr)
	)
	else
		$error("line_ram: unknown address while enabled");

endmodule

// ==== line_guard/line_guard.sv ====
`timescale 1ns/1ps

module line_guard
	import line_pkg::*;
#(
	parameter logic [31:0] PORT_KEY  = 32'h5A17_C3E1,
	parameter int          ADDR_BITS = 8
)
(
	input  logic      sys_clock,
	input  logic      reset,

	// Refill port side
	input  port_req_t req_i,
	input  logic      req_valid_i,
	output logic      req_ready_o,
	output port_rsp_t rsp_o,
	output logic      rsp_valid_o,
	input  logic      rsp_ready_i,

	// Arbiter side
	output mem_req_t  mem_req_o,
	output logic      mem_valid_o,
	input  logic      mem_ready_i,
	input  logic      mem_done_i,
	input  line_u     mem_rdata_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_WAIT,
		ST_RESP
	} state_t;

	state_t      state_q;
	mem_req_t    mem_req_q;
	port_rsp_t   rsp_q;
	logic [15:0] addr_in;
	line_u       ks_in;
	line_u       ks_held;
	line_u       wdata_scr;
	line_u       rdata_plain;

	// Only the RAM-sized part of the address is kept
	assign addr_in = 16'(req_i.addr[ADDR_BITS-1:0]);

	//////////////////////////////////////////////////////////////////////
	// Scramble on the way in, unscramble on the way back
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		ks_in   = keystream(PORT_KEY, addr_in);
		ks_held = keystream(PORT_KEY, mem_req_q.addr);
		for (int k = 0; k < LINE_WORDS; k++)
		begin
			wdata_scr.words[k]   = req_i.data.words[k] ^ ks_in.words[k];
			rdata_plain.words[k] = mem_rdata_i.words[k] ^ ks_held.words[k];
		end
	end

	// Transaction sequencing
	always_ff @(posedge sys_clock)
	begin
		if (reset)
		begin
			state_q <= ST_IDLE;
		end
		else
		begin
			case (state_q)
				ST_IDLE:
					if (req_valid_i)
						state_q <= ST_ISSUE;
				ST_ISSUE:
					if (mem_ready_i)
						state_q <= ST_WAIT;
				ST_WAIT:
					if (mem_done_i)
						state_q <= ST_RESP;
				default:
					if (rsp_ready_i)
						state_q <= ST_IDLE;
			endcase
		end
	end

	// Held request and response words
	always_ff @(posedge sys_clock)
	begin
		if (state_q == ST_IDLE && req_valid_i)
		begin
			mem_req_q.write <= req_i.write;
			mem_req_q.addr  <= addr_in;
			mem_req_q.data  <= wdata_scr;
		end
		if (state_q == ST_WAIT && mem_done_i)
		begin
			// Write ack carries an all-zero line
			rsp_q.data <= mem_req_q.write ? line_u'('0) : rdata_plain;
			rsp_q.ack  <= mem_req_q.write;
		end
	end

	assign req_ready_o = (state_q == ST_IDLE);
	assign mem_valid_o = (state_q == ST_ISSUE);
	assign mem_req_o   = mem_req_q;
	assign rsp_valid_o = (state_q == ST_RESP);
	assign rsp_o       = rsp_q;

	// Back-pressure must not drop or alter a pending response
	a_rsp_hold : assert property (
		@(posedge sys_clock) disable iff (reset)
		rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o)
	)
	else
		$error("line_guard: response changed before it was taken");

endmodule

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter
	import line_pkg::*;
#(
	parameter int NUM_PORTS = 2
)
(
	input  logic                 sys_clock,
	input  logic                 reset,

	// Guard side
	input  mem_req_t             req_i [NUM_PORTS],
	input  logic [NUM_PORTS-1:0] valid_i,
	output logic [NUM_PORTS-1:0] ready_o,
	output logic [NUM_PORTS-1:0] done_o,
	output line_u                rdata_o,

	// RAM side
	output logic                 ram_en_o,
	output mem_req_t             ram_req_o,
	input  line_u                ram_rdata_i
);

	localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

	logic                 busy_q;
	logic [NUM_PORTS-1:0] issue_q;
	logic [NUM_PORTS-1:0] done_q;
	logic [IDX_W-1:0]     winner;
	logic                 grant;
	mem_req_t             ram_req_q;

	//////////////////////////////////////////////////////////////////////
	// Winner selection
	//////////////////////////////////////////////////////////////////////

	// Highest requesting port wins so the data port comes first
	always_comb
	begin
		winner = '0;
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			if (valid_i[p])
				winner = IDX_W'(p);
		end
	end

	// A port in flight keeps the grant and nobody else gets in
	assign grant = !busy_q && (|valid_i);

	always_comb
	begin
		ready_o = '0;
		if (grant)
			ready_o[winner] = 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Transaction pipeline of grant, RAM enable and done
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clock)
	begin
		if (reset)
		begin
			busy_q  <= 1'b0;
			issue_q <= '0;
			done_q  <= '0;
		end
		else
		begin
			// Each stage carries the owning port as a one-hot flag
			issue_q <= ready_o;
			// RAM latency covered by one stage for reads and writes alike
			done_q  <= issue_q;
			if (grant)
			begin
				busy_q <= 1'b1;
			end
			else if (|done_q)
			begin
				busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge sys_clock)
	begin
		if (grant)
			ram_req_q <= req_i[winner];
	end

	// Done comes from the stage flag of the port that owns the grant
	assign done_o = done_q;

	// Read line is broadcast and only the done port picks it up
	assign rdata_o   = ram_rdata_i;
	assign ram_en_o  = |issue_q;
	assign ram_req_o = ram_req_q;

	a_done_onehot : assert property (
		@(posedge sys_clock) disable iff (reset)
		$onehot0(done_o)
	)
	else
		$error("mem_arbiter: more than one done at once");

	// No new grant until the outstanding transaction completes
	a_single_outstanding : assert property (
		@(posedge sys_clock) disable iff (reset)
		grant |=> (!grant) [*2]
	)
	else
		$error("mem_arbiter: grant while a transaction was outstanding");

endmodule

// ==== hdl/secure_mem_top.sv ====
`timescale 1ns/1ps

module secure_mem_top
	import line_pkg::*;
#(
	parameter int          NUM_PORTS = 2,
	parameter int          ADDR_BITS = 8,
	parameter logic [31:0] KEY_BASE  = 32'h5A17_C3E1
)
(
	input  logic                 sys_clock,
	input  logic                 reset,

	// Port 0 is instruction refill, the top port is data refill
	input  port_req_t            req_i [NUM_PORTS],
	input  logic [NUM_PORTS-1:0] req_valid_i,
	output logic [NUM_PORTS-1:0] req_ready_o,
	output port_rsp_t            rsp_o [NUM_PORTS],
	output logic [NUM_PORTS-1:0] rsp_valid_o,
	input  logic [NUM_PORTS-1:0] rsp_ready_i
);

	// Guard to arbiter
	mem_req_t             mem_req [NUM_PORTS];
	logic [NUM_PORTS-1:0] mem_valid;
	logic [NUM_PORTS-1:0] mem_ready;
	logic [NUM_PORTS-1:0] mem_done;
	line_u                mem_rdata;

	// Arbiter to RAM
	logic                 ram_en;
	mem_req_t             ram_req;
	line_u                ram_rdata;

	//////////////////////////////////////////////////////////////////////
	// One protection unit per port, each with its own key
	//////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < NUM_PORTS; g++)
	begin : g_guard
		line_guard #(
			.PORT_KEY  (KEY_BASE + 32'(g)),
			.ADDR_BITS (ADDR_BITS)
		) u_line_guard (
			.sys_clock   (sys_clock),
			.reset       (reset),
			.req_i       (req_i[g]),
			.req_valid_i (req_valid_i[g]),
			.req_ready_o (req_ready_o[g]),
			.rsp_o       (rsp_o[g]),
			.rsp_valid_o (rsp_valid_o[g]),
			.rsp_ready_i (rsp_ready_i[g]),
			.mem_req_o   (mem_req[g]),
			.mem_valid_o (mem_valid[g]),
			.mem_ready_i (mem_ready[g]),
			.mem_done_i  (mem_done[g]),
			.mem_rdata_i (mem_rdata)
		);
	end

	mem_arbiter #(
		.NUM_PORTS (NUM_PORTS)
	) u_mem_arbiter (
		.sys_clock   (sys_clock),
		.reset       (reset),
		.req_i       (mem_req),
		.valid_i     (mem_valid),
		.ready_o     (mem_ready),
		.done_o      (mem_done),
		.rdata_o     (mem_rdata),
		.ram_en_o    (ram_en),
		.ram_req_o   (ram_req),
		.ram_rdata_i (ram_rdata)
	);

	line_ram #(
		.ADDR_BITS (ADDR_BITS)
	) u_line_ram (
		.sys_clock (sys_clock),
		.reset     (reset),
		.en_i      (ram_en),
		.req_i     (ram_req),
		.rdata_o   (ram_rdata)
	);

endmodule

// ==== testbench/mem_checker.sv ====
`timescale 1ns/1ps

module mem_checker
	import line_pkg::*;
#(
	parameter int          NUM_PORTS = 2,
	parameter int          ADDR_BITS = 8,
	parameter logic [31:0] KEY_BASE  = 32'h5A17_C3E1
)
(
	input  logic                 sys_clock,
	input  logic                 reset,
	input  port_req_t            req_i [NUM_PORTS],
	input  logic [NUM_PORTS-1:0] req_valid_i,
	input  logic [NUM_PORTS-1:0] req_ready_i,
	input  port_rsp_t            rsp_i [NUM_PORTS],
	input  logic [NUM_PORTS-1:0] rsp_valid_i,
	input  logic [NUM_PORTS-1:0] rsp_ready_i,
	input  logic [2:0]           test_idx_i,
	input  logic                 test_end_i,
	output int                   check_count_o,
	output int                   error_count_o
);

	localparam int DEPTH = 1 << ADDR_BITS;

	// Plaintext last written to each line and the port that wrote it
	logic [127:0]         shadow_plain [DEPTH];
	int                   shadow_port  [DEPTH];
	logic                 shadow_valid [DEPTH];
	port_req_t            held         [NUM_PORTS];
	port_rsp_t            rsp_d        [NUM_PORTS];
	logic [NUM_PORTS-1:0] in_flight;
	logic [NUM_PORTS-1:0] valid_d;
	logic [NUM_PORTS-1:0] ready_d;
	int                   checks;
	int                   errors;
	int                   test_checks;
	int                   test_errors;

	function automatic string test_name(input logic [2:0] idx);
		case (idx)
			3'd0:    return "reset_state";
			3'd1:    return "round_trip";
			3'd2:    return "cross_port";
			3'd3:    return "contention";
			default: return "back_pressure";
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Word k is key ^ addr*0x9E3779B9 ^ k*0x01010101
	function automatic logic [127:0] line_pad(input logic [31:0] key, input logic [31:0] addr);
		logic [127:0] pad;
		for (int k = 0; k < 4; k++)
			pad[32*k +: 32] = key ^ (addr * 32'h9E37_79B9) ^ (32'(k) * 32'h0101_0101);
		return pad;
	endfunction

	// Write gives zero line plus ack, read strips writer pad and applies reader pad
	function automatic logic [128:0] expected_rsp(input logic write, input int reader,
			input int writer, input logic [127:0] plain, input logic [31:0] addr);
		if (write)
			return {128'h0, 1'b1};
		return {plain ^ line_pad(KEY_BASE + 32'(writer), addr)
			^ line_pad(KEY_BASE + 32'(reader), addr), 1'b0};
	endfunction

	task automatic note_failure(input string what);
		errors++;
		test_errors++;
		$display("%s: %s", test_name(test_idx_i), what);
	endtask

	task automatic compare(input int p, input logic [128:0] exp);
		checks++;
		test_checks++;
		if (rsp_i[p] !== exp)
		begin
			errors++;
			test_errors++;
			$display("ERR %s port %0d: expected %h actual %h",
				test_name(test_idx_i), p, exp, rsp_i[p]);
		end
	endtask

	task automatic check_port(input int p);
		logic [ADDR_BITS-1:0] a;
		logic                 stalled;
		a       = held[p].addr[ADDR_BITS-1:0];
		stalled = valid_d[p] && !ready_d[p];
		if (test_idx_i == 3'd0)
		begin
			checks++;
			test_checks++;
			if (rsp_valid_i[p] || !req_ready_i[p])
				note_failure($sformatf("port %0d is not idle after reset", p));
		end
		if (in_flight[p] && req_ready_i[p])
			note_failure($sformatf("port %0d took requests while one was in flight", p));
		if (stalled && (!rsp_valid_i[p] || rsp_i[p] !== rsp_d[p]))
			note_failure($sformatf("port %0d response dropped or changed while stalled", p));
		// A new response shows up in RAM completion order
		if (rsp_valid_i[p] && !stalled)
		begin
			if (!in_flight[p])
				note_failure($sformatf("port %0d gave a response with no request", p));
			else if (held[p].write)
			begin
				shadow_plain[a] = held[p].data.raw;
				shadow_port[a]  = p;
				shadow_valid[a] = 1'b1;
				compare(p, expected_rsp(1'b1, p, p, '0, 32'(a)));
			end
			else if (shadow_valid[a])
				compare(p, expected_rsp(1'b0, p, shadow_port[a], shadow_plain[a], 32'(a)));
		end
		if (rsp_valid_i[p] && rsp_ready_i[p])
			in_flight[p] = 1'b0;
		if (req_valid_i[p] && req_ready_i[p])
		begin
			held[p]      = req_i[p];
			in_flight[p] = 1'b1;
		end
		valid_d[p] = rsp_valid_i[p];
		ready_d[p] = rsp_ready_i[p];
		rsp_d[p]   = rsp_i[p];
	endtask

	task automatic report_test();
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			if (in_flight[p])
				note_failure($sformatf("port %0d still waits for a response", p));
		end
		$display("test %s: %0d checks, %0d errors", test_name(test_idx_i),
			test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	always @(posedge sys_clock)
	begin
		if (reset)
		begin
			in_flight   = '0;
			valid_d     = '0;
			ready_d     = '0;
			checks      = 0;
			errors      = 0;
			test_checks = 0;
			test_errors = 0;
			for (int a = 0; a < DEPTH; a++)
				shadow_valid[a] = 1'b0;
		end
		else
		begin
			for (int p = 0; p < NUM_PORTS; p++)
				check_port(p);
			if (test_end_i)
				report_test();
		end
	end

	assign check_count_o = checks;
	assign error_count_o = errors;

endmodule

// ==== testbench/tb_secure_mem.sv ====
`timescale 1ns/1ps

module tb_secure_mem
	import line_pkg::*;
();

	localparam int          NUM_PORTS    = 2;
	localparam int          ADDR_BITS    = 8;
	localparam logic [31:0] KEY_BASE     = 32'h5A17_C3E1;
	localparam int          RESET_CYCLES = 10;
	localparam int          RAND_TXNS    = 12;
	// Directed traffic, then two random phases on both ports
	localparam int          TOTAL_TXNS   = 24 + 2 * NUM_PORTS * RAND_TXNS;

	logic                 sys_clock = 1'b0;
	logic                 reset;
	port_req_t            req [NUM_PORTS];
	logic [NUM_PORTS-1:0] req_valid;
	logic [NUM_PORTS-1:0] req_ready;
	port_rsp_t            rsp [NUM_PORTS];
	logic [NUM_PORTS-1:0] rsp_valid;
	logic [NUM_PORTS-1:0] rsp_ready;
	logic [2:0]           test_idx;
	logic                 test_end;
	int                   check_count;
	int                   error_count;
	int                   seed;

	// Random traffic drawn ahead of each phase, one row per port
	logic                 txn_wr   [NUM_PORTS][RAND_TXNS];
	logic [7:0]           txn_addr [NUM_PORTS][RAND_TXNS];
	logic [127:0]         txn_data [NUM_PORTS][RAND_TXNS];
	int                   txn_hold [NUM_PORTS][RAND_TXNS];

	// 4 ns period
	always #2 sys_clock = ~sys_clock;

	secure_mem_top #(
		.NUM_PORTS (NUM_PORTS),
		.ADDR_BITS (ADDR_BITS),
		.KEY_BASE  (KEY_BASE)
	) u_secure_mem_top (
		.sys_clock   (sys_clock),
		.reset       (reset),
		.req_i       (req),
		.req_valid_i (req_valid),
		.req_ready_o (req_ready),
		.rsp_o       (rsp),
		.rsp_valid_o (rsp_valid),
		.rsp_ready_i (rsp_ready)
	);

	mem_checker #(
		.NUM_PORTS (NUM_PORTS),
		.ADDR_BITS (ADDR_BITS),
		.KEY_BASE  (KEY_BASE)
	) u_mem_checker (
		.sys_clock     (sys_clock),
		.reset         (reset),
		.req_i         (req),
		.req_valid_i   (req_valid),
		.req_ready_i   (req_ready),
		.rsp_i         (rsp),
		.rsp_valid_i   (rsp_valid),
		.rsp_ready_i   (rsp_ready),
		.test_idx_i    (test_idx),
		.test_end_i    (test_end),
		.check_count_o (check_count),
		.error_count_o (error_count)
	);

	function automatic logic [127:0] random_line();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	task automatic draw_traffic(input int max_hold);
		logic [31:0] r;
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			for (int i = 0; i < RAND_TXNS; i++)
			begin
				r              = $random(seed);
				txn_wr[p][i]   = r[0];
				txn_addr[p][i] = 8'h10 + {5'd0, r[3:1]};
				txn_hold[p][i] = int'(r[7:4]) % (max_hold + 1);
				txn_data[p][i] = random_line();
			end
		end
	endtask

	// One transaction, rsp_ready held low for hold cycles of a valid response
	task automatic do_txn(input int p, input logic wr, input logic [7:0] addr,
			input logic [127:0] data, input int hold);
		int stalled;
		stalled           = 0;
		req[p].write     <= wr;
		req[p].addr      <= {8'h00, addr};
		req[p].data.raw  <= data;
		req_valid[p]     <= 1'b1;
		rsp_ready[p]     <= (hold == 0);
		@(posedge sys_clock);
		while (!req_ready[p])
			@(posedge sys_clock);
		req_valid[p] <= 1'b0;
		@(posedge sys_clock);
		while (!(rsp_valid[p] && rsp_ready[p]))
		begin
			if (rsp_valid[p])
			begin
				stalled++;
				if (stalled >= hold)
					rsp_ready[p] <= 1'b1;
			end
			@(posedge sys_clock);
		end
	endtask

	task automatic run_port(input int p);
		for (int i = 0; i < RAND_TXNS; i++)
			do_txn(p, txn_wr[p][i], txn_addr[p][i], txn_data[p][i], txn_hold[p][i]);
	endtask

	task automatic run_both();
		fork
			run_port(0);
			run_port(1);
		join
	endtask

	task automatic end_test();
		test_end <= 1'b1;
		@(posedge sys_clock);
		test_end <= 1'b0;
		test_idx <= test_idx + 3'd1;
		@(posedge sys_clock);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		seed      = 32'hd3ca_f438;
		reset     <= 1'b1;
		req_valid <= '0;
		rsp_ready <= '1;
		test_idx  <= 3'd0;
		test_end  <= 1'b0;
		for (int p = 0; p < NUM_PORTS; p++)
			req[p] <= '0;
		repeat (RESET_CYCLES) @(posedge sys_clock);
		reset <= 1'b0;

		// Idle outputs are checked each cycle while this test is open
		repeat (5) @(posedge sys_clock);
		end_test();

		for (int p = 0; p < NUM_PORTS; p++)
		begin
			for (int i = 0; i < 4; i++)
				do_txn(p, 1'b1, 8'h10 + 8'(4 * p + i), random_line(), 0);
			for (int i = 0; i < 4; i++)
				do_txn(p, 1'b0, 8'h10 + 8'(4 * p + i), '0, 0);
		end
		end_test();

		// Written under the instruction key, read under the data key
		for (int i = 0; i < 4; i++)
			do_txn(0, 1'b1, 8'h18 + 8'(i), random_line(), 0);
		for (int i = 0; i < 4; i++)
			do_txn(1, 1'b0, 8'h18 + 8'(i), '0, 0);
		end_test();

		draw_traffic(0);
		run_both();
		end_test();

		draw_traffic(7);
		run_both();
		end_test();

		@(posedge sys_clock);
		$display("tests 5, checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Watchdog, 40 cycles per planned transaction on top of reset
	initial
	begin
		repeat (RESET_CYCLES + 40 * TOTAL_TXNS) @(posedge sys_clock);
		$display("Timeout: the tests did not finish within %0d cycles",
			RESET_CYCLES + 40 * TOTAL_TXNS);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== sim.f ====
common/line_pkg.sv
hdl/line_ram.sv
line_guard/line_guard.sv
hdl/mem_arbiter.sv
hdl/secure_mem_top.sv
testbench/mem_checker.sv
testbench/tb_secure_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the secure memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_secure_mem --Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_secure_mem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
